/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mc_host_bridge
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
mc_noc_pkg.sv
mc_host_pkg.sv
mc_sipo.sv
mc_piso.sv
mc_fifo_small.sv
mc_endpoint_fifos.sv
mc_host_bridge.sv
tb_mc_host_bridge.sv

/* mc_endpoint_fifos.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_endpoint_fifos
  import mc_noc_pkg::*;
#(
  parameter  int credits_max_p   = 4,
  localparam int credit_width_lp = $clog2(credits_max_p + 1)
) (
  input  logic                       mc_req_sif,
  input  logic                       arst_n_i,

  input  logic [mc_x_width_gp-1:0]   global_x_i,
  input  logic [mc_y_width_gp-1:0]   global_y_i,

  input  mc_packet_u                 endpoint_req_i,
  input  logic                       endpoint_req_v_i,
  output logic                       endpoint_req_ready_o,

  input  mc_packet_u                 endpoint_rsp_i,
  input  logic                       endpoint_rsp_v_i,
  output logic                       endpoint_rsp_ready_o,

  output mc_packet_u                 mc_req_o,
  output logic                       mc_req_v_o,
  input  logic                       mc_req_ready_i,

  output mc_packet_u                 mc_rsp_o,
  output logic                       mc_rsp_v_o,
  input  logic                       mc_rsp_ready_i,

  output mc_packet_u                 link_fwd_o,
  output logic                       link_fwd_v_o,
  input  logic                       link_fwd_ready_i,

  input  mc_packet_u                 link_rev_i,
  input  logic                       link_rev_v_i,
  output logic                       link_rev_ready_o,

  input  mc_packet_u                 link_fwd_i,
  input  logic                       link_fwd_v_i,
  output logic                       link_fwd_ready_o,

  output mc_packet_u                 link_rev_o,
  output logic                       link_rev_v_o,
  input  logic                       link_rev_ready_i,

  output logic [credit_width_lp-1:0] credits_used_o
);

  ////////////////////////////////////////////////////////////////////////////
  // host to mesh

  mc_packet_u                 stamped;
  mc_packet_u                 fwd_r;
  mc_packet_u                 rev_r;
  logic                       fwd_v_r;
  logic                       rev_v_r;
  logic [credit_width_lp-1:0] credits_r;
  logic                       req_fire;
  logic                       rsp_fire;
  logic                       rev_in_fire;

  // source coordinates always come from this tile
  always_comb begin
    stamped           = endpoint_req_i;
    stamped.req.src_x = global_x_i;
    stamped.req.src_y = global_y_i;
  end

  assign endpoint_req_ready_o = (credits_r != credit_width_lp'(credits_max_p))
                              & (~fwd_v_r | link_fwd_ready_i);
  assign endpoint_rsp_ready_o = ~rev_v_r | link_rev_ready_i;
  assign req_fire             = endpoint_req_v_i & endpoint_req_ready_o;
  assign rsp_fire             = endpoint_rsp_v_i & endpoint_rsp_ready_o;

  assign link_fwd_o   = fwd_r;
  assign link_fwd_v_o = fwd_v_r;
  assign link_rev_o   = rev_r;
  assign link_rev_v_o = rev_v_r;

  always_ff @(posedge mc_req_sif or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fwd_v_r <= 1'b0;
      rev_v_r <= 1'b0;
    end else begin
      if (req_fire) begin
        fwd_v_r <= 1'b1;
      end else if (link_fwd_ready_i) begin
        fwd_v_r <= 1'b0;
      end
      if (rsp_fire) begin
        rev_v_r <= 1'b1;
      end else if (link_rev_ready_i) begin
        rev_v_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge mc_req_sif) begin
    if (req_fire) begin
      fwd_r <= stamped;
    end
    if (rsp_fire) begin
      rev_r <= endpoint_rsp_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // mesh to host straight into the buffers

  assign mc_req_o         = link_fwd_i;
  assign mc_req_v_o       = link_fwd_v_i;
  assign link_fwd_ready_o = mc_req_ready_i;

  assign mc_rsp_o         = link_rev_i;
  assign mc_rsp_v_o       = link_rev_v_i;
  assign link_rev_ready_o = mc_rsp_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // credits

  // one credit per request in flight until its response comes back
  assign rev_in_fire = link_rev_v_i & link_rev_ready_o;

  always_ff @(posedge mc_req_sif or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credits_r <= '0;
    end else begin
      credits_r <= credits_r + credit_width_lp'(req_fire)
                             - credit_width_lp'(rev_in_fire);
    end
  end

  assign credits_used_o = credits_r;

  a_credit_max: assert property (@(posedge mc_req_sif) disable iff (!arst_n_i)
    credits_r <= credit_width_lp'(credits_max_p));

  // a response with nothing outstanding came from nowhere
  a_credit_underflow: assert property (@(posedge mc_req_sif) disable iff (!arst_n_i)
    rev_in_fire |-> credits_r != '0);

endmodule

`default_nettype wire

/* mc_fifo_small.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_fifo_small
  import mc_noc_pkg::*;
#(
  parameter int els_p = 4
) (
  input  logic       mc_req_sif,
  input  logic       arst_n_i,

  input  logic       v_i,
  input  mc_packet_u data_i,
  output logic       ready_o,

  output logic       v_o,
  output mc_packet_u data_o,
  input  logic       yumi_i
);

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  mc_packet_u              mem_r [els_p];
  logic [ptr_width_lp-1:0] rptr_r;
  logic [ptr_width_lp-1:0] wptr_r;
  logic [cnt_width_lp-1:0] cnt_r;
  logic                    enq;

  assign enq     = v_i & ready_o;
  assign ready_o = (cnt_r != cnt_width_lp'(els_p));
  assign v_o     = (cnt_r != '0);
  assign data_o  = mem_r[rptr_r];

  always_ff @(posedge mc_req_sif or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_r <= '0;
      wptr_r <= '0;
      cnt_r  <= '0;
    end else begin
      if (enq) begin
        wptr_r <= (wptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (yumi_i) begin
        rptr_r <= (rptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      case ({enq, yumi_i})
        2'b10:   cnt_r <= cnt_r + 1'b1;
        2'b01:   cnt_r <= cnt_r - 1'b1;
        default: cnt_r <= cnt_r;
      endcase
    end
  end

  always_ff @(posedge mc_req_sif) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  // a write must never land on an entry that is still unread
  a_no_write_full: assert property (@(posedge mc_req_sif) disable iff (!arst_n_i)
    enq && (wptr_r == rptr_r) |-> (cnt_r == '0));

endmodule

`default_nettype wire

/* mc_host_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_host_bridge
  import mc_noc_pkg::*;
  import mc_host_pkg::*;
#(
  parameter int els_p         = 4,
  parameter int credits_max_p = 4
) (
  input  logic                             mc_req_sif,
  input  logic                             arst_n_i,
  input  logic                             reset_done_i,
  input  logic [mc_x_width_gp-1:0]         global_x_i,
  input  logic [mc_y_width_gp-1:0]         global_y_i,

  input  logic [mc_host_word_width_gp-1:0] host_req_word_i,
  input  logic                             host_req_v_i,
  output logic                             host_req_ready_o,
  input  logic [mc_host_word_width_gp-1:0] host_rsp_word_i,
  input  logic                             host_rsp_v_i,
  output logic                             host_rsp_ready_o,

  output logic [mc_host_word_width_gp-1:0] mc_req_word_o,
  output logic                             mc_req_v_o,
  input  logic                             mc_req_ready_i,
  output logic [mc_host_word_width_gp-1:0] mc_rsp_word_o,
  output logic                             mc_rsp_v_o,
  input  logic                             mc_rsp_ready_i,

  input  logic [2:0]                       reg_addr_i,
  output logic [mc_host_word_width_gp-1:0] reg_data_o,

  output mc_packet_u                       link_fwd_o,
  output logic                             link_fwd_v_o,
  input  logic                             link_fwd_ready_i,
  input  mc_packet_u                       link_rev_i,
  input  logic                             link_rev_v_i,
  output logic                             link_rev_ready_o,
  input  mc_packet_u                       link_fwd_i,
  input  logic                             link_fwd_v_i,
  output logic                             link_fwd_ready_o,
  output mc_packet_u                       link_rev_o,
  output logic                             link_rev_v_o,
  input  logic                             link_rev_ready_i
);

  localparam int credit_width_lp = $clog2(credits_max_p + 1);
  localparam int rom_sel_lp      = $clog2(mc_rom_els_gp);

  mc_packet_u ep_req, ep_rsp;
  logic       ep_req_v, ep_req_ready, ep_rsp_v, ep_rsp_ready;

  mc_packet_u fifo_req_in, fifo_rsp_in, fifo_req_out, fifo_rsp_out;
  logic       fifo_req_in_v, fifo_req_in_ready, fifo_rsp_in_v, fifo_rsp_in_ready;
  logic       fifo_req_out_v, fifo_rsp_out_v, piso_req_ready, piso_rsp_ready;

  logic [credit_width_lp-1:0] credits_used;
  logic [2:0]                 rom_idx;

  ////////////////////////////////////////////////////////////////////////////
  // host words in

  mc_sipo i_req_sipo (
    .mc_req_sif, .arst_n_i,
    .v_i(host_req_v_i), .data_i(host_req_word_i), .ready_o(host_req_ready_o),
    .v_o(ep_req_v), .data_o(ep_req), .yumi_i(ep_req_v & ep_req_ready)
  );

  mc_sipo i_rsp_sipo (
    .mc_req_sif, .arst_n_i,
    .v_i(host_rsp_v_i), .data_i(host_rsp_word_i), .ready_o(host_rsp_ready_o),
    .v_o(ep_rsp_v), .data_o(ep_rsp), .yumi_i(ep_rsp_v & ep_rsp_ready)
  );

  mc_endpoint_fifos #(.credits_max_p(credits_max_p)) i_endpoint (
    .mc_req_sif, .arst_n_i, .global_x_i, .global_y_i,
    .endpoint_req_i(ep_req), .endpoint_req_v_i(ep_req_v),
    .endpoint_req_ready_o(ep_req_ready),
    .endpoint_rsp_i(ep_rsp), .endpoint_rsp_v_i(ep_rsp_v),
    .endpoint_rsp_ready_o(ep_rsp_ready),
    .mc_req_o(fifo_req_in), .mc_req_v_o(fifo_req_in_v), .mc_req_ready_i(fifo_req_in_ready),
    .mc_rsp_o(fifo_rsp_in), .mc_rsp_v_o(fifo_rsp_in_v), .mc_rsp_ready_i(fifo_rsp_in_ready),
    .link_fwd_o, .link_fwd_v_o, .link_fwd_ready_i,
    .link_rev_i, .link_rev_v_i, .link_rev_ready_o,
    .link_fwd_i, .link_fwd_v_i, .link_fwd_ready_o,
    .link_rev_o, .link_rev_v_o, .link_rev_ready_i,
    .credits_used_o(credits_used)
  );

  ////////////////////////////////////////////////////////////////////////////
  // mesh packets out to host words

  mc_fifo_small #(.els_p(els_p)) i_req_fifo (
    .mc_req_sif, .arst_n_i,
    .v_i(fifo_req_in_v), .data_i(fifo_req_in), .ready_o(fifo_req_in_ready),
    .v_o(fifo_req_out_v), .data_o(fifo_req_out), .yumi_i(fifo_req_out_v & piso_req_ready)
  );

  mc_fifo_small #(.els_p(els_p)) i_rsp_fifo (
    .mc_req_sif, .arst_n_i,
    .v_i(fifo_rsp_in_v), .data_i(fifo_rsp_in), .ready_o(fifo_rsp_in_ready),
    .v_o(fifo_rsp_out_v), .data_o(fifo_rsp_out), .yumi_i(fifo_rsp_out_v & piso_rsp_ready)
  );

  mc_piso i_req_piso (
    .mc_req_sif, .arst_n_i,
    .v_i(fifo_req_out_v), .data_i(fifo_req_out), .ready_o(piso_req_ready),
    .v_o(mc_req_v_o), .data_o(mc_req_word_o), .ready_i(mc_req_ready_i)
  );

  mc_piso i_rsp_piso (
    .mc_req_sif, .arst_n_i,
    .v_i(fifo_rsp_out_v), .data_i(fifo_rsp_out), .ready_o(piso_rsp_ready),
    .v_o(mc_rsp_v_o), .data_o(mc_rsp_word_o), .ready_i(mc_rsp_ready_i)
  );

  // register read port
  assign rom_idx = reg_addr_i - 3'(mc_rom_base_gp);

  always_comb begin
    reg_data_o = '0;
    if (reg_addr_i == 3'(mc_reg_reset_done_gp)) begin
      reg_data_o[0] = reset_done_i;
    end else if (reg_addr_i == 3'(mc_reg_credits_gp)) begin
      reg_data_o[credit_width_lp-1:0] = credits_used;
    end else if (rom_idx < 3'(mc_rom_els_gp)) begin
      reg_data_o = mc_rom_arr_gp[rom_idx[rom_sel_lp-1:0]];
    end
  end

endmodule

`default_nettype wire

/* mc_host_pkg.sv */
`default_nettype none

package mc_host_pkg;

  localparam int mc_host_word_width_gp = 32;
  localparam int mc_words_per_pkt_gp   = 4;

  // register file layout
  localparam int mc_reg_reset_done_gp = 0;
  localparam int mc_reg_credits_gp    = 1;
  localparam int mc_rom_base_gp       = 2;
  localparam int mc_rom_els_gp        = 4;

  // configuration ROM listed from word 3 down to word 0
  localparam logic [mc_rom_els_gp-1:0][mc_host_word_width_gp-1:0] mc_rom_arr_gp = {
    32'h0000_0004,  // credit limit
    32'h0000_0000,  // host x/y
    32'h0004_0004,  // mesh size with y in the upper half
    32'h0001_0000   // version
  };

endpackage

`default_nettype wire

/* mc_noc_pkg.sv */
`default_nettype none

package mc_noc_pkg;

  localparam int mc_packet_width_gp = 128;
  localparam int mc_addr_width_gp   = 32;
  localparam int mc_data_width_gp   = 32;
  localparam int mc_x_width_gp      = 8;
  localparam int mc_y_width_gp      = 8;
  localparam int mc_op_width_gp     = 4;
  localparam int mc_load_id_width_gp = 8;

  // unused upper bits of each view
  localparam int mc_req_pad_width_gp = mc_packet_width_gp - mc_op_width_gp
    - mc_addr_width_gp - mc_data_width_gp - 2 * (mc_x_width_gp + mc_y_width_gp);
  localparam int mc_rsp_pad_width_gp = mc_packet_width_gp - mc_op_width_gp
    - mc_data_width_gp - mc_load_id_width_gp - mc_x_width_gp - mc_y_width_gp;

  typedef enum logic [mc_op_width_gp-1:0] {
    e_op_load     = 4'h0,
    e_op_store    = 4'h1,
    e_op_response = 4'h2
  } mc_op_e;

  typedef struct packed {
    logic [mc_req_pad_width_gp-1:0] pad;
    logic [mc_y_width_gp-1:0]       dst_y;
    logic [mc_x_width_gp-1:0]       dst_x;
    logic [mc_y_width_gp-1:0]       src_y;
    logic [mc_x_width_gp-1:0]       src_x;
    logic [mc_data_width_gp-1:0]    data;
    logic [mc_addr_width_gp-1:0]    addr;
    mc_op_e                         op;
  } mc_req_pkt_s;

  typedef struct packed {
    logic [mc_rsp_pad_width_gp-1:0] pad;
    logic [mc_y_width_gp-1:0]       dst_y;
    logic [mc_x_width_gp-1:0]       dst_x;
    logic [mc_load_id_width_gp-1:0] load_id;
    logic [mc_data_width_gp-1:0]    data;
    mc_op_e                         op;
  } mc_rsp_pkt_s;

  // requests on the forward path, responses on the reverse path
  typedef union packed {
    mc_req_pkt_s req;
    mc_rsp_pkt_s rsp;
  } mc_packet_u;

endpackage

`default_nettype wire

/* mc_piso.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_piso
  import mc_noc_pkg::*;
  import mc_host_pkg::*;
(
  input  logic                             mc_req_sif,
  input  logic                             arst_n_i,

  input  logic                             v_i,
  input  mc_packet_u                       data_i,
  output logic                             ready_o,

  output logic                             v_o,
  output logic [mc_host_word_width_gp-1:0] data_o,
  input  logic                             ready_i
);

  localparam int sel_width_lp = $clog2(mc_words_per_pkt_gp);

  logic                    busy_r;
  logic [sel_width_lp:0]   idx_r;
  logic [mc_words_per_pkt_gp-1:0][mc_host_word_width_gp-1:0] word_r;

  assign ready_o = ~busy_r;
  assign v_o     = busy_r;
  assign data_o  = word_r[idx_r[sel_width_lp-1:0]];

  always_ff @(posedge mc_req_sif or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end else if (v_i & ready_o) begin
      busy_r <= 1'b1;
      idx_r  <= '0;
    end else if (v_o & ready_i) begin
      if (idx_r == (sel_width_lp + 1)'(mc_words_per_pkt_gp - 1)) begin
        busy_r <= 1'b0;
        idx_r  <= '0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  always_ff @(posedge mc_req_sif) begin
    if (v_i & ready_o) begin
      word_r <= data_i;
    end
  end

  a_idx_in_range: assert property (@(posedge mc_req_sif) disable iff (!arst_n_i)
    idx_r < (sel_width_lp + 1)'(mc_words_per_pkt_gp));

endmodule

`default_nettype wire

/* mc_sipo.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_sipo
  import mc_noc_pkg::*;
  import mc_host_pkg::*;
(
  input  logic                             mc_req_sif,
  input  logic                             arst_n_i,

  input  logic                             v_i,
  input  logic [mc_host_word_width_gp-1:0] data_i,
  output logic                             ready_o,

  output logic                             v_o,
  output mc_packet_u                       data_o,
  input  logic                             yumi_i
);

  localparam int cnt_width_lp = $clog2(mc_words_per_pkt_gp);

  logic [cnt_width_lp-1:0] cnt_r;
  logic                    full_r;
  logic [mc_words_per_pkt_gp-1:0][mc_host_word_width_gp-1:0] word_r;
  logic                    accept;

  assign accept  = v_i & ready_o;
  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = word_r;

  always_ff @(posedge mc_req_sif or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_r  <= '0;
      full_r <= 1'b0;
    end else if (accept) begin
      cnt_r <= cnt_r + 1'b1;
      if (cnt_r == cnt_width_lp'(mc_words_per_pkt_gp - 1)) begin
        full_r <= 1'b1;
      end
    end else if (yumi_i) begin
      full_r <= 1'b0;
    end
  end

  // low word first
  always_ff @(posedge mc_req_sif) begin
    if (accept) begin
      word_r[cnt_r] <= data_i;
    end
  end

  // consumer may only take a finished packet
  a_yumi_needs_v: assert property (@(posedge mc_req_sif) disable iff (!arst_n_i)
    yumi_i |-> v_o);

endmodule

`default_nettype wire

/* tb_mc_host_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mc_host_bridge
  import mc_noc_pkg::*;
  import mc_host_pkg::*;
;

  localparam int period_lp     = 40;
  localparam int els_lp        = 4;
  localparam int credits_lp    = 4;
  localparam int timeout_lp    = 200;
  localparam int rows_lp       = 4;
  localparam int word_w_lp     = mc_host_word_width_gp;
  localparam int link_fwd_lp   = 0;
  localparam int link_rev_lp   = 1;
  localparam int q_fwd_lp      = 0;
  localparam int q_rev_lp      = 1;
  localparam int q_req_lp      = 2;
  localparam int q_rsp_lp      = 3;

  // columns are op, address, data, destination x and destination y
  localparam mc_op_e tbl_op [rows_lp] = '{e_op_load, e_op_store, e_op_store, e_op_load};
  localparam logic [31:0] tbl_addr [rows_lp] =
    '{32'h0000_1000, 32'h0000_2004, 32'h8000_0010, 32'hffff_fffc};
  localparam logic [31:0] tbl_data [rows_lp] =
    '{32'h0000_0000, 32'hdead_beef, 32'h1234_5678, 32'ha5a5_5a5a};
  localparam logic [7:0] tbl_dst_x [rows_lp] = '{8'h00, 8'h01, 8'h03, 8'h02};
  localparam logic [7:0] tbl_dst_y [rows_lp] = '{8'h01, 8'h02, 8'h00, 8'h03};

  logic                     clk;
  logic                     arst_n;
  logic                     reset_done;
  logic [mc_x_width_gp-1:0] gx;
  logic [mc_y_width_gp-1:0] gy;
  logic [word_w_lp-1:0]     host_req_word, host_rsp_word, mc_req_word, mc_rsp_word;
  logic                     host_req_v, host_req_ready, host_rsp_v, host_rsp_ready;
  logic                     mc_req_v, mc_req_ready, mc_rsp_v, mc_rsp_ready;
  logic [2:0]               reg_addr;
  logic [word_w_lp-1:0]     reg_data;
  mc_packet_u               link_fwd_out, link_rev_in, link_fwd_in, link_rev_out;
  logic                     link_fwd_out_v, link_fwd_out_ready, link_rev_in_v, link_rev_in_ready;
  logic                     link_fwd_in_v, link_fwd_in_ready, link_rev_out_v, link_rev_out_ready;

  mc_packet_u               fwd_q [$];
  mc_packet_u               rev_q [$];
  logic [word_w_lp-1:0]     req_word_q [$];
  logic [word_w_lp-1:0]     rsp_word_q [$];

  mc_packet_u               req_pkt [rows_lp];
  mc_packet_u               rsp_pkt [rows_lp];
  integer                   seed;
  int                       fail_cnt, check_cnt, test_cnt, test_fail_cnt;

  mc_host_bridge #(.els_p(els_lp), .credits_max_p(credits_lp)) i_mc_host_bridge (
    .mc_req_sif(clk), .arst_n_i(arst_n), .reset_done_i(reset_done),
    .global_x_i(gx), .global_y_i(gy),
    .host_req_word_i(host_req_word), .host_req_v_i(host_req_v),
    .host_req_ready_o(host_req_ready),
    .host_rsp_word_i(host_rsp_word), .host_rsp_v_i(host_rsp_v),
    .host_rsp_ready_o(host_rsp_ready),
    .mc_req_word_o(mc_req_word), .mc_req_v_o(mc_req_v), .mc_req_ready_i(mc_req_ready),
    .mc_rsp_word_o(mc_rsp_word), .mc_rsp_v_o(mc_rsp_v), .mc_rsp_ready_i(mc_rsp_ready),
    .reg_addr_i(reg_addr), .reg_data_o(reg_data),
    .link_fwd_o(link_fwd_out), .link_fwd_v_o(link_fwd_out_v),
    .link_fwd_ready_i(link_fwd_out_ready),
    .link_rev_i(link_rev_in), .link_rev_v_i(link_rev_in_v),
    .link_rev_ready_o(link_rev_in_ready),
    .link_fwd_i(link_fwd_in), .link_fwd_v_i(link_fwd_in_v),
    .link_fwd_ready_o(link_fwd_in_ready),
    .link_rev_o(link_rev_out), .link_rev_v_o(link_rev_out_v),
    .link_rev_ready_i(link_rev_out_ready)
  );

  initial clk = 1'b0;
  always #(period_lp / 2) clk = ~clk;

  // mesh and host sinks keep one entry per accepted transfer
  always @(posedge clk) begin
    if (link_fwd_out_v && link_fwd_out_ready) fwd_q.push_back(link_fwd_out);
    if (link_rev_out_v && link_rev_out_ready) rev_q.push_back(link_rev_out);
    if (mc_req_v && mc_req_ready) req_word_q.push_back(mc_req_word);
    if (mc_rsp_v && mc_rsp_ready) rsp_word_q.push_back(mc_rsp_word);
  end

  ////////////////////////////////////////////////////////////////////////////
  // packet builders

  function automatic logic [mc_packet_width_gp-1:0] rand_fill();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic mc_packet_u make_req(input int row);
    mc_packet_u p;
    logic [mc_packet_width_gp-1:0] r;
    r = rand_fill();
    p = '0;
    p.req.op    = tbl_op[row];
    p.req.addr  = tbl_addr[row];
    p.req.data  = tbl_data[row];
    p.req.src_x = 8'hee;
    p.req.src_y = 8'(row) + 8'hc0;
    p.req.dst_x = tbl_dst_x[row];
    p.req.dst_y = tbl_dst_y[row];
    p.req.pad   = r[mc_packet_width_gp-1 -: mc_req_pad_width_gp];
    return p;
  endfunction

  function automatic mc_packet_u make_rsp(input int row);
    mc_packet_u p;
    logic [mc_packet_width_gp-1:0] r;
    r = rand_fill();
    p = '0;
    p.rsp.op      = e_op_response;
    p.rsp.data    = ~tbl_data[row];
    p.rsp.load_id = 8'(row) + 8'h10;
    p.rsp.dst_x   = tbl_dst_x[row];
    p.rsp.dst_y   = tbl_dst_y[row];
    p.rsp.pad     = r[mc_packet_width_gp-1 -: mc_rsp_pad_width_gp];
    return p;
  endfunction

  // what the mesh should see for a host request
  function automatic mc_packet_u stamp_src(input mc_packet_u p);
    mc_packet_u e;
    e = p;
    e.req.src_x = gx;
    e.req.src_y = gy;
    return e;
  endfunction

  function automatic int queue_size(input int which);
    int n;
    n = 0;
    case (which)
      q_fwd_lp: n = fwd_q.size();
      q_rev_lp: n = rev_q.size();
      q_req_lp: n = req_word_q.size();
      default:  n = rsp_word_q.size();
    endcase
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // drivers and checkers

  task automatic wait_queue(input int which, input int n, input string what, output bit ok);
    int waited;
    waited = 0;
    while (queue_size(which) < n && waited < timeout_lp) begin
      @(negedge clk);
      waited++;
    end
    ok = (queue_size(which) >= n);
    if (!ok) begin
      $display("%0t: timed out waiting for %s", $time, what);
      fail_cnt++;
    end
  endtask

  task automatic send_words(input bit to_rsp, input mc_packet_u pkt);
    logic [mc_packet_width_gp-1:0] bits;
    int waited;
    bits = pkt;
    for (int w = 0; w < mc_words_per_pkt_gp; w++) begin
      @(negedge clk);
      if (to_rsp) begin
        host_rsp_word = bits[w*word_w_lp +: word_w_lp];
        host_rsp_v    = 1'b1;
      end else begin
        host_req_word = bits[w*word_w_lp +: word_w_lp];
        host_req_v    = 1'b1;
      end
      waited = 0;
      while (!(to_rsp ? host_rsp_ready : host_req_ready) && waited < timeout_lp) begin
        @(negedge clk);
        waited++;
      end
      if (waited == timeout_lp) begin
        $display("%0t: host channel never took word %0d", $time, w);
        fail_cnt++;
      end
    end
    @(negedge clk);
    host_req_v = 1'b0;
    host_rsp_v = 1'b0;
  endtask

  task automatic push_link(input int which, input mc_packet_u pkt);
    int waited;
    @(negedge clk);
    if (which == link_fwd_lp) begin
      link_fwd_in   = pkt;
      link_fwd_in_v = 1'b1;
    end else begin
      link_rev_in   = pkt;
      link_rev_in_v = 1'b1;
    end
    waited = 0;
    while (!(which == link_fwd_lp ? link_fwd_in_ready : link_rev_in_ready)
           && waited < timeout_lp) begin
      @(negedge clk);
      waited++;
    end
    if (waited == timeout_lp) begin
      $display("%0t: mesh link %0d never accepted a packet", $time, which);
      fail_cnt++;
    end
    @(negedge clk);
    link_fwd_in_v = 1'b0;
    link_rev_in_v = 1'b0;
  endtask

  task automatic expect_pkt(input int which, input mc_packet_u exp, input string what);
    mc_packet_u got;
    bit ok;
    wait_queue(which, 1, what, ok);
    if (ok) begin
      got = (which == q_fwd_lp) ? fwd_q.pop_front() : rev_q.pop_front();
      check_cnt++;
      if (got !== exp) begin
        $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        fail_cnt++;
      end
    end
  endtask

  task automatic expect_words(input int which, input mc_packet_u pkt, input string what);
    logic [mc_packet_width_gp-1:0] bits;
    logic [word_w_lp-1:0] got;
    bit ok;
    bits = pkt;
    wait_queue(which, mc_words_per_pkt_gp, what, ok);
    if (ok) begin
      for (int w = 0; w < mc_words_per_pkt_gp; w++) begin
        if (which == q_req_lp) begin
          got = req_word_q.pop_front();
        end else begin
          got = rsp_word_q.pop_front();
        end
        check_cnt++;
        if (got !== bits[w*word_w_lp +: word_w_lp]) begin
          $display("[FAIL] %0t: %s word %0d got %h expected %h", $time, what, w, got,
                   bits[w*word_w_lp +: word_w_lp]);
          fail_cnt++;
        end
      end
    end
  endtask

  task automatic expect_reg(input logic [2:0] addr, input logic [word_w_lp-1:0] exp);
    @(negedge clk);
    reg_addr = addr;
    #(period_lp / 4);
    check_cnt++;
    if (reg_data !== exp) begin
      $display("[FAIL] %0t: register %0d reads %h expected %h", $time, addr, reg_data, exp);
      fail_cnt++;
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    test_cnt++;
    if (fail_cnt == errs_before) begin
      $display("test %0d %s: passed", test_cnt, name);
    end else begin
      $display("test %0d %s: %0d errors", test_cnt, name, fail_cnt - errs_before);
      test_fail_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    int errs;
    int waited;
    logic [word_w_lp-1:0] held;
    mc_packet_u extra, mesh_a, mesh_b;

    seed = 88818;
    fail_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    test_fail_cnt = 0;
    arst_n = 1'b0;
    reset_done = 1'b0;
    gx = 8'h02;
    gy = 8'h01;
    host_req_word = '0;
    host_req_v = 1'b0;
    host_rsp_word = '0;
    host_rsp_v = 1'b0;
    mc_req_ready = 1'b1;
    mc_rsp_ready = 1'b1;
    reg_addr = '0;
    link_fwd_out_ready = 1'b1;
    link_rev_out_ready = 1'b1;
    link_rev_in = '0;
    link_rev_in_v = 1'b0;
    link_fwd_in = '0;
    link_fwd_in_v = 1'b0;
    for (int i = 0; i < rows_lp; i++) begin
      req_pkt[i] = make_req(i);
      rsp_pkt[i] = make_rsp(i);
    end

    repeat (4) @(negedge clk);
    arst_n = 1'b1;
    reset_done = 1'b1;

    errs = fail_cnt;
    @(negedge clk);
    check_cnt++;
    if ({link_fwd_out_v, link_rev_out_v, mc_req_v, mc_rsp_v} !== 4'b0000) begin
      $display("[FAIL] %0t: a valid output is high after reset", $time);
      fail_cnt++;
    end
    for (int a = 0; a < 8; a++) begin
      if (a == mc_reg_reset_done_gp) begin
        expect_reg(3'(a), 32'd1);
      end else if (a >= mc_rom_base_gp && a < mc_rom_base_gp + mc_rom_els_gp) begin
        expect_reg(3'(a), mc_rom_arr_gp[a - mc_rom_base_gp]);
      end else begin
        expect_reg(3'(a), 32'd0);
      end
    end
    close_test("registers after reset", errs);

    errs = fail_cnt;
    for (int i = 0; i < rows_lp; i++) begin
      send_words(1'b0, req_pkt[i]);
      expect_pkt(q_fwd_lp, stamp_src(req_pkt[i]), "host request on link_fwd_o");
    end
    expect_reg(3'(mc_reg_credits_gp), 32'(rows_lp));
    close_test("host requests to mesh", errs);

    errs = fail_cnt;
    for (int i = 0; i < rows_lp; i++) begin
      push_link(link_rev_lp, rsp_pkt[i]);
      expect_words(q_rsp_lp, rsp_pkt[i], "mesh response on mc_rsp_word_o");
    end
    expect_reg(3'(mc_reg_credits_gp), 32'd0);
    close_test("mesh responses to host", errs);

    // one request more than the credit limit allows
    errs = fail_cnt;
    extra = make_req(0);
    for (int i = 0; i < credits_lp; i++) begin
      send_words(1'b0, req_pkt[i % rows_lp]);
    end
    send_words(1'b0, extra);
    for (int i = 0; i < credits_lp; i++) begin
      expect_pkt(q_fwd_lp, stamp_src(req_pkt[i % rows_lp]), "request below credit limit");
    end
    repeat (10) @(negedge clk);
    check_cnt++;
    if (fwd_q.size() != 0) begin
      $display("[FAIL] %0t: request over the credit limit reached link_fwd_o", $time);
      fail_cnt++;
    end
    expect_reg(3'(mc_reg_credits_gp), 32'(credits_lp));
    push_link(link_rev_lp, rsp_pkt[0]);
    expect_pkt(q_fwd_lp, stamp_src(extra), "held request after a credit returned");
    expect_reg(3'(mc_reg_credits_gp), 32'(credits_lp));
    for (int i = 0; i < credits_lp; i++) begin
      push_link(link_rev_lp, rsp_pkt[(i + 1) % rows_lp]);
    end
    expect_reg(3'(mc_reg_credits_gp), 32'd0);
    for (int i = 0; i <= credits_lp; i++) begin
      expect_words(q_rsp_lp, rsp_pkt[i % rows_lp], "credit return response");
    end
    close_test("credit limit", errs);

    errs = fail_cnt;
    @(negedge clk);
    mc_req_ready = 1'b0;
    mesh_a = make_req(2);
    mesh_b = make_req(3);
    push_link(link_fwd_lp, mesh_a);
    push_link(link_fwd_lp, mesh_b);
    waited = 0;
    while (!mc_req_v && waited < timeout_lp) begin
      @(negedge clk);
      waited++;
    end
    if (!mc_req_v) begin
      $display("%0t: mc_req_v_o never rose for a mesh request", $time);
      fail_cnt++;
    end else begin
      held = mc_req_word;
      for (int k = 0; k < 6; k++) begin
        @(negedge clk);
        check_cnt++;
        if (!mc_req_v || mc_req_word !== held) begin
          $display("[FAIL] %0t: mc_req word moved while stalled", $time);
          fail_cnt++;
        end
      end
    end
    @(negedge clk);
    mc_req_ready = 1'b1;
    expect_words(q_req_lp, mesh_a, "first mesh request");
    expect_words(q_req_lp, mesh_b, "second mesh request");
    close_test("mesh requests with stall", errs);

    errs = fail_cnt;
    for (int i = 0; i < rows_lp; i++) begin
      send_words(1'b1, rsp_pkt[i]);
      expect_pkt(q_rev_lp, rsp_pkt[i], "host response on link_rev_o");
    end
    close_test("host responses to mesh", errs);

    $display("%0d tests, %0d failed, %0d checks, %0d errors", test_cnt, test_fail_cnt,
             check_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
